// ==== kbd_pkg.sv ====
package kbd_pkg;

    // bit 8 is the E0 extended flag, bits 7..0 the scan code
    typedef logic [8:0] key_code_t;

    localparam key_code_t LEFT_SHIFT_CODE  = 9'h012;
    localparam key_code_t RIGHT_SHIFT_CODE = 9'h059;

    localparam logic [7:0] BREAK_PREFIX = 8'hF0;  // key release follows
    localparam logic [7:0] EXT_PREFIX   = 8'hE0;  // extended key follows

    localparam int NUM_DIGIT_KEYS = 20;

    // entry i stands for digit i mod 10
    localparam key_code_t DIGIT_KEY_CODES [0:NUM_DIGIT_KEYS-1] = '{
        9'h045,  // 0
        9'h016,  // 1
        9'h01E,  // 2
        9'h026,  // 3
        9'h025,  // 4
        9'h02E,  // 5
        9'h036,  // 6
        9'h03D,  // 7
        9'h03E,  // 8
        9'h046,  // 9
        9'h070,  // keypad 0
        9'h069,  // keypad 1
        9'h072,  // keypad 2
        9'h07A,  // keypad 3
        9'h06B,  // keypad 4
        9'h073,  // keypad 5
        9'h074,  // keypad 6
        9'h06C,  // keypad 7
        9'h075,  // keypad 8
        9'h07D   // keypad 9
    };

    localparam logic [3:0] BLANK_NIBBLE = 4'hF;  // empty position

    localparam int NUM_DIGITS     = 4;
    localparam int DIGIT_SEL_BITS = $clog2(NUM_DIGITS);

    // short for simulation, a board build wants a much wider prescaler
    localparam int SCAN_DIV_BITS = 4;

    typedef enum logic [1:0] {
        IDLE,    // waiting for a start bit
        DATA,    // eight data bits, lsb first
        PARITY,  // odd parity bit
        STOP     // stop bit, must be high
    } rx_state_t;

endpackage

// ==== ps2_frame_rx.sv ====
`timescale 1ns/1ps

module ps2_frame_rx (
    input  logic       clk,
    input  logic       rst,
    input  logic       ps2_clk,
    input  logic       ps2_data,
    output logic [7:0] rx_byte,
    output logic       rx_valid
);
    import kbd_pkg::*;

    rx_state_t  state;
    logic [1:0] clk_sync;   // two-flop synchronizer for ps2_clk
    logic [1:0] data_sync;  // same depth for ps2_data
    logic       clk_sync_d;
    logic       fall_q;     // registered falling edge of ps2_clk
    logic       data_q;     // data bit aligned with fall_q
    logic [2:0] bit_cnt;
    logic       parity_acc;
    logic       parity_ok;
    logic [7:0] shreg;

    // lines idle high, so the synchronizer resets to 1 to avoid a false edge
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            clk_sync   <= 2'b11;
            data_sync  <= 2'b11;
            clk_sync_d <= 1'b1;
            fall_q     <= 1'b0;
            data_q     <= 1'b1;
        end else begin
            clk_sync   <= {clk_sync[0], ps2_clk};
            data_sync  <= {data_sync[0], ps2_data};
            clk_sync_d <= clk_sync[1];
            fall_q     <= clk_sync_d & ~clk_sync[1];
            data_q     <= data_sync[1];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= IDLE;
            bit_cnt    <= 3'd0;
            parity_acc <= 1'b0;
            parity_ok  <= 1'b0;
            rx_valid   <= 1'b0;
        end else begin
            rx_valid <= 1'b0;  // single-cycle strobe
            if (fall_q) begin
                case (state)
                    IDLE: begin
                        if (!data_q) begin  // start bit
                            state      <= DATA;
                            bit_cnt    <= 3'd0;
                            parity_acc <= 1'b0;
                        end
                    end
                    DATA: begin
                        parity_acc <= parity_acc ^ data_q;
                        bit_cnt    <= bit_cnt + 3'd1;
                        if (bit_cnt == 3'd7) begin
                            state <= PARITY;
                        end
                    end
                    PARITY: begin
                        parity_ok <= parity_acc ^ data_q;  // odd count of ones
                        state     <= STOP;
                    end
                    STOP: begin
                        rx_valid <= data_q & parity_ok;  // bad frames just vanish
                        state    <= IDLE;
                    end
                    default: state <= IDLE;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fall_q && state == DATA) begin
            shreg <= {data_q, shreg[7:1]};  // lsb arrives first
        end
        if (fall_q && state == STOP) begin
            rx_byte <= shreg;
        end
    end

endmodule

// ==== key_state_tracker.sv ====
`timescale 1ns/1ps

module key_state_tracker (
    input  logic              clk,
    input  logic              rst,
    input  logic [7:0]        rx_byte,
    input  logic              rx_valid,
    output logic [511:0]      key_down,
    output kbd_pkg::key_code_t last_change,
    output logic              key_press
);
    import kbd_pkg::*;

    logic      ext_flag;    // set by E0 until the code byte
    logic      brk_flag;    // set by F0 so the next code is a release
    logic      code_done;   // byte that completes a key code
    key_code_t new_code;

    assign code_done = rx_valid && rx_byte != EXT_PREFIX && rx_byte != BREAK_PREFIX;
    assign new_code  = {ext_flag, rx_byte};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ext_flag  <= 1'b0;
            brk_flag  <= 1'b0;
            key_down  <= '0;
            key_press <= 1'b0;
        end else begin
            key_press <= 1'b0;
            if (rx_valid) begin
                if (rx_byte == EXT_PREFIX) begin
                    ext_flag <= 1'b1;
                end else if (rx_byte == BREAK_PREFIX) begin
                    brk_flag <= 1'b1;
                end else begin
                    if (brk_flag) begin
                        key_down[new_code] <= 1'b0;  // release
                    end else begin
                        key_down[new_code] <= 1'b1;
                        // typematic repeats find the bit already set
                        key_press <= ~key_down[new_code];
                    end
                    ext_flag <= 1'b0;
                    brk_flag <= 1'b0;
                end
            end
        end
    end

    // code of the latest make or break
    always_ff @(posedge clk) begin
        if (code_done) begin
            last_change <= new_code;
        end
    end

endmodule

// ==== digit_entry.sv ====
`timescale 1ns/1ps

module digit_entry (
    input  logic               clk,
    input  logic               rst,
    input  logic               key_press,
    input  kbd_pkg::key_code_t last_change,
    input  logic [1:0]         shift_held,
    output logic [15:0]        nums
);
    import kbd_pkg::*;

    logic [3:0] key_num;   // digit value or blank
    logic       is_digit;
    logic       shift_on;  // either shift key

    // table lookup, main row and keypad give the same digit
    always_comb begin
        key_num = BLANK_NIBBLE;
        for (int i = 0; i < NUM_DIGIT_KEYS; i++) begin
            if (last_change == DIGIT_KEY_CODES[i]) begin
                key_num = 4'(i % 10);
            end
        end
    end

    assign is_digit = key_num != BLANK_NIBBLE;
    assign shift_on = |shift_held;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            nums <= {NUM_DIGITS{BLANK_NIBBLE}};  // all positions dark
        end else if (key_press && is_digit) begin
            if (shift_on) begin
                nums <= {nums[11:0], key_num};   // enter at the right
            end else begin
                nums <= {key_num, nums[15:4]};   // enter at the left
            end
        end
    end

endmodule

// ==== seven_seg_scan.sv ====
`timescale 1ns/1ps

module seven_seg_scan (
    input  logic        clk,
    input  logic        rst,
    input  logic [15:0] nums,
    output logic [3:0]  digit,
    output logic [6:0]  display
);
    import kbd_pkg::*;

    logic [SCAN_DIV_BITS-1:0]  prescale;
    logic [DIGIT_SEL_BITS-1:0] sel;     // active position, 3 is leftmost
    logic [3:0]                nibble;

    // active-low gfedcba
    function automatic logic [6:0] seg_encode(input logic [3:0] value);
        case (value)
            4'd0:    seg_encode = 7'b100_0000;
            4'd1:    seg_encode = 7'b111_1001;
            4'd2:    seg_encode = 7'b010_0100;
            4'd3:    seg_encode = 7'b011_0000;
            4'd4:    seg_encode = 7'b001_1001;
            4'd5:    seg_encode = 7'b001_0010;
            4'd6:    seg_encode = 7'b000_0010;
            4'd7:    seg_encode = 7'b111_1000;
            4'd8:    seg_encode = 7'b000_0000;
            4'd9:    seg_encode = 7'b001_0000;
            default: seg_encode = 7'b111_1111;  // A-F stay dark
        endcase
    endfunction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            prescale <= '0;
            sel      <= DIGIT_SEL_BITS'(NUM_DIGITS - 1);
        end else begin
            prescale <= prescale + 1'b1;
            if (&prescale) begin
                sel <= sel - 1'b1;  // wraps from 0 back to 3
            end
        end
    end

    assign nibble  = nums[{sel, 2'b00} +: 4];
    assign digit   = ~(4'b0001 << sel);  // one anode low at a time
    assign display = seg_encode(nibble);

endmodule

// ==== kbd_display_top.sv ====
`timescale 1ns/1ps

module kbd_display_top (
    input  logic       clk,
    input  logic       rst,
    input  logic       ps2_clk,
    input  logic       ps2_data,
    output logic [3:0] digit,
    output logic [6:0] display
);
    import kbd_pkg::*;

    logic [7:0]   rx_byte;
    logic         rx_valid;
    logic [511:0] key_down;
    key_code_t    last_change;
    logic         key_press;
    logic [15:0]  nums;

    ps2_frame_rx rx_i (
        .clk      (clk),
        .rst      (rst),
        .ps2_clk  (ps2_clk),
        .ps2_data (ps2_data),
        .rx_byte  (rx_byte),
        .rx_valid (rx_valid)
    );

    key_state_tracker tracker_i (
        .clk         (clk),
        .rst         (rst),
        .rx_byte     (rx_byte),
        .rx_valid    (rx_valid),
        .key_down    (key_down),
        .last_change (last_change),
        .key_press   (key_press)
    );

    // only the two shift bits of the key map reach the entry block
    digit_entry entry_i (
        .clk         (clk),
        .rst         (rst),
        .key_press   (key_press),
        .last_change (last_change),
        .shift_held  ({key_down[RIGHT_SHIFT_CODE], key_down[LEFT_SHIFT_CODE]}),
        .nums        (nums)
    );

    seven_seg_scan scan_i (
        .clk     (clk),
        .rst     (rst),
        .nums    (nums),
        .digit   (digit),
        .display (display)
    );

endmodule

// ==== tb_kbd_display.sv ====
`timescale 1ns/1ps

module tb_kbd_display;
    import kbd_pkg::*;

    localparam int HALF_BIT   = 8;   // ps2 half period in clk cycles
    localparam int IDLE_GAP   = 16;  // idle clk cycles after each frame
    localparam int SCAN_CLKS  = NUM_DIGITS * (2 ** SCAN_DIV_BITS);
    localparam int FRAME_CLKS = 11 * 2 * HALF_BIT + IDLE_GAP + 1;
    localparam int NUM_PLAIN  = 12;
    localparam int NUM_MIXED  = 16;

    // frame count over all tests with six frames per shifted press
    localparam int MAX_FRAMES   = NUM_PLAIN * 3 + NUM_MIXED * 6 + 22 + 4;
    localparam int MAX_READS    = 1 + NUM_PLAIN + NUM_MIXED + 8 + 2;
    localparam int TIMEOUT_CLKS = 2 * (MAX_FRAMES * FRAME_CLKS + MAX_READS * SCAN_CLKS + 16);

    // main row 0-9, then keypad 0-9
    localparam logic [8:0] DIGIT_KEYS [0:19] = '{
        9'h045, 9'h016, 9'h01E, 9'h026, 9'h025, 9'h02E, 9'h036, 9'h03D, 9'h03E, 9'h046,
        9'h070, 9'h069, 9'h072, 9'h07A, 9'h06B, 9'h073, 9'h074, 9'h06C, 9'h075, 9'h07D
    };

    // A, B, space, enter, backspace, tab
    localparam logic [8:0] OTHER_KEYS [0:5] = '{
        9'h01C, 9'h032, 9'h029, 9'h05A, 9'h066, 9'h00D
    };

    logic       clk;
    logic       rst;
    logic       ps2_clk;
    logic       ps2_data;
    logic [3:0] digit;
    logic [6:0] display;

    integer       seed = 32'h6195_ae45;
    int           cycle_count = 0;
    int           errors = 0;
    int           test_errors = 0;
    int           checks = 0;
    int           tests_ok = 0;
    int           tests_bad = 0;
    logic [15:0]  exp_nums;   // reference display register
    logic [511:0] held_keys;  // reference key-down set

    kbd_display_top dut_i (
        .clk      (clk),
        .rst      (rst),
        .ps2_clk  (ps2_clk),
        .ps2_data (ps2_data),
        .digit    (digit),
        .display  (display)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CLKS) begin
            $display("timeout: the run did not finish within %0d clock cycles", TIMEOUT_CLKS);
            $display("test failed");
            $finish;
        end
    end

    function automatic int digit_of(input logic [8:0] code);
        int d;
        d = -1;  // not a digit key
        for (int i = 0; i < 20; i++) begin
            if (DIGIT_KEYS[i] == code) begin
                d = i % 10;
            end
        end
        return d;
    endfunction

    // active-low gfedcba back to a nibble where dark means blank
    function automatic logic [3:0] seg_to_nibble(input logic [6:0] seg);
        case (seg)
            7'b100_0000: return 4'd0;
            7'b111_1001: return 4'd1;
            7'b010_0100: return 4'd2;
            7'b011_0000: return 4'd3;
            7'b001_1001: return 4'd4;
            7'b001_0010: return 4'd5;
            7'b000_0010: return 4'd6;
            7'b111_1000: return 4'd7;
            7'b000_0000: return 4'd8;
            7'b001_0000: return 4'd9;
            7'b111_1111: return 4'hF;
            default:     return 4'hE;  // no valid pattern
        endcase
    endfunction

    task automatic check_value(input string name, input logic [15:0] expected,
                               input logic [15:0] actual);
        checks++;
        if (actual !== expected) begin
            $display("[FAIL] %s: expected %h, got %h", name, expected, actual);
            errors++;
            test_errors++;
        end
    endtask

    // applied only once a correct frame has completed the code
    task automatic model_key(input logic [8:0] code, input logic brk);
        int d;
        if (brk) begin
            held_keys[code] = 1'b0;
        end else if (!held_keys[code]) begin
            held_keys[code] = 1'b1;
            d = digit_of(code);
            if (d >= 0) begin
                if (held_keys[LEFT_SHIFT_CODE] || held_keys[RIGHT_SHIFT_CODE]) begin
                    exp_nums = {exp_nums[11:0], 4'(d)};  // enters at the right
                end else begin
                    exp_nums = {4'(d), exp_nums[15:4]};  // enters at the left
                end
            end
        end
    endtask

    task automatic send_frame(input logic [7:0] data, input logic bad_parity);
        logic [10:0] bits;
        logic        par;
        par = ~^data;  // odd parity
        if (bad_parity) begin
            par = ~par;
        end
        bits = {1'b1, par, data, 1'b0};  // stop, parity, data, start
        @(posedge clk);
        for (int i = 0; i < 11; i++) begin
            ps2_data <= bits[i];
            repeat (HALF_BIT) @(posedge clk);
            ps2_clk <= 1'b0;
            repeat (HALF_BIT) @(posedge clk);
            ps2_clk <= 1'b1;
        end
        ps2_data <= 1'b1;
        repeat (IDLE_GAP) @(posedge clk);
    endtask

    task automatic send_make(input logic [8:0] code);
        if (code[8]) begin
            send_frame(8'hE0, 1'b0);
        end
        send_frame(code[7:0], 1'b0);
        model_key(code, 1'b0);
    endtask

    task automatic send_break(input logic [8:0] code);
        if (code[8]) begin
            send_frame(8'hE0, 1'b0);
        end
        send_frame(8'hF0, 1'b0);
        send_frame(code[7:0], 1'b0);
        model_key(code, 1'b1);
    endtask

    task automatic press_key(input logic [8:0] code);
        send_make(code);
        send_break(code);
    endtask

    // one full scan round sampled on the falling clk edge
    task automatic read_display(output logic [15:0] shown);
        logic [3:0] seen;
        shown = 16'hEEEE;
        seen  = 4'b0000;
        repeat (SCAN_CLKS) begin
            @(negedge clk);
            for (int p = 0; p < 4; p++) begin
                if (digit == ~(4'b0001 << p)) begin
                    shown[p*4 +: 4] = seg_to_nibble(display);
                    seen[p] = 1'b1;
                end
            end
        end
        if (seen != 4'b1111) begin
            $display("anode scan did not reach every position in one round (seen %b)", seen);
            errors++;
            test_errors++;
        end
    endtask

    task automatic verify_display();
        logic [15:0] shown;
        read_display(shown);
        check_value("nums", exp_nums, shown);
    endtask

    task automatic finish_test(input string name);
        if (test_errors == 0) begin
            $display("%-14s ok", name);
            tests_ok++;
        end else begin
            $display("%-14s %0d error(s)", name, test_errors);
            tests_bad++;
        end
        test_errors = 0;
    endtask

    initial begin
        int unsigned idx;
        logic [8:0]  key;
        logic [8:0]  shift_key;
        logic        use_shift;
        rst       = 1'b1;
        ps2_clk   = 1'b1;  // idle bus
        ps2_data  = 1'b1;
        exp_nums  = 16'hFFFF;
        held_keys = '0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        repeat (2) @(posedge clk);

        verify_display();
        finish_test("reset_blank");

        repeat (NUM_PLAIN) begin
            idx = {$random(seed)} % 20;
            press_key(DIGIT_KEYS[idx]);
            verify_display();
        end
        finish_test("plain_digits");

        repeat (NUM_MIXED) begin
            idx       = {$random(seed)} % 20;
            use_shift = ($random(seed) & 1) != 0;
            shift_key = ($random(seed) & 1) ? RIGHT_SHIFT_CODE : LEFT_SHIFT_CODE;
            if (use_shift) begin
                send_make(shift_key);
            end
            press_key(DIGIT_KEYS[idx]);
            if (use_shift) begin
                send_break(shift_key);
            end
            verify_display();
        end
        finish_test("shift_digits");

        repeat (3) begin
            idx = {$random(seed)} % 6;
            press_key(OTHER_KEYS[idx]);
            verify_display();
        end
        press_key(9'h170);  // extended E0 70 is not keypad 0
        verify_display();
        idx = {$random(seed)} % 20;
        key = DIGIT_KEYS[idx];
        send_make(key);
        verify_display();
        repeat (3) send_make(key);  // typematic repeats
        verify_display();
        send_break(key);
        verify_display();
        idx = {$random(seed)} % 20;
        send_break(DIGIT_KEYS[idx]);  // release of a key not held
        verify_display();
        finish_test("ignored_keys");

        idx = {$random(seed)} % 20;
        key = DIGIT_KEYS[idx];
        send_frame(key[7:0], 1'b1);  // dropped so the reference stays as it is
        verify_display();
        press_key(key);
        verify_display();
        finish_test("bad_parity");

        $display("tests: %0d ok, %0d with errors; checks: %0d, errors: %0d",
                 tests_ok, tests_bad, checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
kbd_pkg.sv
ps2_frame_rx.sv
key_state_tracker.sv
digit_entry.sv
seven_seg_scan.sv
kbd_display_top.sv
tb_kbd_display.sv

// ==== Bender.yml ====
package:
  name: kbd_display

sources:
  - kbd_pkg.sv
  - ps2_frame_rx.sv
  - key_state_tracker.sv
  - digit_entry.sv
  - seven_seg_scan.sv
  - kbd_display_top.sv
  - target: simulation
    files:
      - tb_kbd_display.sv
